//--- verilog.f
src/MemStagePkg.sv
src/StoreFormatter.sv
src/DataRam.sv
src/LoadAligner.sv
src/MemStage.sv
bench/MemStageTb.sv

//--- Makefile
BIN := obj_dir/VMemStageTb
SRCS := $(wildcard src/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module MemStageTb

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- bench/MemStageTb.sv
`timescale 1ns/1ps

module MemStageTb;

  import MemStagePkg::*;

  logic            clk;
  logic            rstN;
  MemReqType       memReq;
  ExceptinPipeType exceptOut;
  logic [31:0]     loadData;
  logic            loadDone;

  MemReqType   reqTable[$];   // Stimulus, one entry per cycle
  string       nameTable[$];
  logic [7:0]  model [0:4095];  // Byte image of the data RAM
  logic [31:0] expectQ[$];    // Load result due next cycle
  string       expectNameQ[$];
  int          cycleCount = 0;
  int          timeoutLimit = 1000;

  MemStage UUT (
    .clk      (clk),
    .rstN     (rstN),
    .memReq   (memReq),
    .exceptOut(exceptOut),
    .loadData (loadData),
    .loadDone (loadDone)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
      $display("Test failures found");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", testName, expected, actual);
      $display("Test failures found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic pushEntry(input string name, input MemReqType req);
    req.exceptIn = ExceptinPipeType'($urandom());  // Random upstream flags
    reqTable.push_back(req);
    nameTable.push_back(name);
  endtask

  task automatic addStore(input string name, input logic [1:0] kind,
                          input logic [31:0] addr, input logic [31:0] operand);
    MemReqType req;
    req = '0;
    req.addr = addr;
    req.storeData = operand;
    req.storeType.DMWr = 1'b1;
    req.storeType.sign = kind;
    pushEntry(name, req);
  endtask

  task automatic addLoad(input string name, input logic [1:0] kind, input logic isUns,
                         input logic [31:0] addr);
    MemReqType req;
    req = '0;
    req.addr = addr;
    req.storeData = $urandom();  // Must never reach the RAM
    req.loadType.ReadMem = 1'b1;
    req.loadType.sign = kind;
    req.loadType.isUnsigned = isUns;
    pushEntry(name, req);
  endtask

  task automatic addIdle(input string name);
    MemReqType req;
    req = '0;
    req.addr = $urandom();
    pushEntry(name, req);
  endtask

  function automatic logic storeMisaligned(input MemReqType req);
    return req.storeType.DMWr &&
           ((req.storeType.sign == StoreSw && req.addr[1:0] != 2'b00) ||
            (req.storeType.sign == StoreSh && req.addr[0]));
  endfunction

  function automatic logic loadMisaligned(input MemReqType req);
    return req.loadType.ReadMem &&
           ((req.loadType.sign == LoadWord && req.addr[1:0] != 2'b00) ||
            (req.loadType.sign == LoadHalf && req.addr[0]));
  endfunction

  function automatic ExceptinPipeType expectedExcept(input MemReqType req);
    ExceptinPipeType e;
    e = req.exceptIn;
    e.WrWrongAddressinMEM = storeMisaligned(req);
    e.RdWrongAddressinMEM = loadMisaligned(req);
    return e;
  endfunction

  // Little endian lanes, byte 0 in bits 7:0
  task automatic applyStore(input MemReqType req);
    logic [11:0] a;
    a = req.addr[11:0];
    if (req.storeType.DMWr && !storeMisaligned(req)) begin
      case (req.storeType.sign)
        StoreSw: begin
          model[{a[11:2], 2'b00}] = req.storeData[7:0];
          model[{a[11:2], 2'b01}] = req.storeData[15:8];
          model[{a[11:2], 2'b10}] = req.storeData[23:16];
          model[{a[11:2], 2'b11}] = req.storeData[31:24];
        end
        StoreSh: begin
          model[{a[11:1], 1'b0}] = req.storeData[7:0];
          model[{a[11:1], 1'b1}] = req.storeData[15:8];
        end
        StoreSb: model[a] = req.storeData[7:0];
        default: ;
      endcase
    end
  endtask

  function automatic logic [31:0] modelLoad(input MemReqType req);
    logic [11:0] a;
    logic [15:0] half;
    logic [7:0]  b;
    a = req.addr[11:0];
    half = {model[{a[11:1], 1'b1}], model[{a[11:1], 1'b0}]};
    b = model[a];
    case (req.loadType.sign)
      LoadHalf: return req.loadType.isUnsigned ? {16'b0, half} : {{16{half[15]}}, half};
      LoadByte: return req.loadType.isUnsigned ? {24'b0, b} : {{24{b[7]}}, b};
      default:  return {model[{a[11:2], 2'b11}], model[{a[11:2], 2'b10}],
                        model[{a[11:2], 2'b01}], model[{a[11:2], 2'b00}]};
    endcase
  endfunction

  // Mid-cycle check of the entry driven at the last rising edge
  task automatic checkCycle(input string name, input MemReqType req);
    ExceptinPipeType expExc;
    logic            expDone;
    logic [31:0]     expData;
    string           loadName;
    expExc = expectedExcept(req);
    checkValue({name, " exceptOut"}, 32'(expExc), 32'(exceptOut));
    expDone = (expectQ.size() > 0);
    loadName = expDone ? expectNameQ[0] : name;
    checkValue({loadName, " loadDone"}, 32'(expDone), 32'(loadDone));
    if (expDone) begin
      expData = expectQ.pop_front();
      void'(expectNameQ.pop_front());
      checkValue({loadName, " loadData"}, expData, loadData);
    end
    applyStore(req);  // Same-edge write lands before the read
    if (req.loadType.ReadMem && !loadMisaligned(req)) begin
      expectQ.push_back(modelLoad(req));
      expectNameQ.push_back(name);
    end
  endtask

  task automatic buildTable();
    addStore("sw_word0", StoreSw, 32'h010, $urandom());
    addLoad("lw_word0", LoadWord, 1'b0, 32'h010);
    addStore("sw_word1", StoreSw, 32'h124, $urandom());
    addLoad("lw_word1", LoadWord, 1'b0, 32'h124);
    addLoad("lw_word0_again", LoadWord, 1'b0, 32'h010);  // Back to back
    addIdle("idle_start");
    // Halves, low one negative and high one positive
    addStore("sw_fill_half", StoreSw, 32'h200, $urandom());
    addStore("sh_low", StoreSh, 32'h200, $urandom() | 32'h0000_8000);
    addStore("sh_high", StoreSh, 32'h202, $urandom() & 32'hFFFF_7FFF);
    addLoad("lh_low", LoadHalf, 1'b0, 32'h200);
    addLoad("lhu_low", LoadHalf, 1'b1, 32'h200);
    addLoad("lh_high", LoadHalf, 1'b0, 32'h202);
    addLoad("lhu_high", LoadHalf, 1'b1, 32'h202);
    addLoad("lw_halves", LoadWord, 1'b0, 32'h200);
    // Bytes, neighbors checked after the first one
    addStore("sw_fill_byte", StoreSw, 32'h300, $urandom());
    addStore("sb_lane1", StoreSb, 32'h301, $urandom() | 32'h80);
    addLoad("lw_after_sb1", LoadWord, 1'b0, 32'h300);
    addStore("sb_lane0", StoreSb, 32'h300, $urandom() & 32'hFFFF_FF7F);
    addStore("sb_lane2", StoreSb, 32'h302, $urandom() | 32'h80);
    addStore("sb_lane3", StoreSb, 32'h303, $urandom() & 32'hFFFF_FF7F);
    for (int i = 0; i < 4; i++) begin
      addLoad($sformatf("lb_lane%0d", i), LoadByte, 1'b0, 32'h300 + 32'(i));
      addLoad($sformatf("lbu_lane%0d", i), LoadByte, 1'b1, 32'h300 + 32'(i));
    end
    addLoad("lw_bytes", LoadWord, 1'b0, 32'h300);
    // Misaligned stores leave memory alone
    addStore("sw_fill_mis", StoreSw, 32'h400, $urandom());
    addStore("sw_mis1", StoreSw, 32'h401, $urandom());
    addStore("sw_mis2", StoreSw, 32'h402, $urandom());
    addStore("sh_mis", StoreSh, 32'h403, $urandom());
    addLoad("lw_after_mis", LoadWord, 1'b0, 32'h400);
    // Misaligned loads give no done pulse
    addLoad("lw_mis", LoadWord, 1'b0, 32'h012);
    addLoad("lh_mis", LoadHalf, 1'b0, 32'h011);
    addLoad("lhu_mis", LoadHalf, 1'b1, 32'h201);
    addLoad("lw_after_rdmis", LoadWord, 1'b0, 32'h124);
    addStore("sb_odd", StoreSb, 32'h403, $urandom());
    addLoad("lb_odd", LoadByte, 1'b0, 32'h403);
    addLoad("lbu_odd", LoadByte, 1'b1, 32'h301);
    addLoad("lw_odd_check", LoadWord, 1'b0, 32'h400);
    addIdle("idle_end");
  endtask

  initial begin
    void'($urandom(54));
    rstN <= 1'b0;
    memReq <= '0;
    buildTable();
    timeoutLimit = 3 * reqTable.size() + 20;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < reqTable.size(); i++) begin
      @(posedge clk);
      memReq <= reqTable[i];
      @(negedge clk);
      checkCycle(nameTable[i], reqTable[i]);
    end
    @(posedge clk);
    memReq <= '0;
    @(negedge clk);
    checkCycle("drain", '0);  // Quiet cycle after the table
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- src/MemStage.sv
`timescale 1ns/1ps

module MemStage (
  input  logic                         clk,
  input  logic                         rstN,
  input  MemStagePkg::MemReqType       memReq,
  output MemStagePkg::ExceptinPipeType exceptOut,
  output logic [31:0]                  loadData,
  output logic                         loadDone
);

  import MemStagePkg::*;

  RamWriteType ramWrite;  // Formatter to RAM
  logic [31:0] ramRdata;  // RAM to aligner

  // Store path and address checks
  StoreFormatter uStoreFormatter (
    .memReq   (memReq),
    .ramWrite (ramWrite),
    .exceptOut(exceptOut)
  );

  // Read address straight from the request
  DataRam uDataRam (
    .clk     (clk),
    .ramWrite(ramWrite),
    .rdAddr  (memReq.addr[RamAddrBits+1:2]),
    .rdata   (ramRdata)
  );

  LoadAligner uLoadAligner (
    .clk     (clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .rdata   (ramRdata),
    .loadData(loadData),
    .loadDone(loadDone)
  );

endmodule

//--- src/LoadAligner.sv
`timescale 1ns/1ps

module LoadAligner (
  input  logic                   clk,
  input  logic                   rstN,
  input  MemStagePkg::MemReqType memReq,
  input  logic [31:0]            rdata,
  output logic [31:0]            loadData,
  output logic                   loadDone
);

  import MemStagePkg::*;

  logic        rdErr;
  logic        pendingQ;   // Load issued last cycle
  logic [1:0]  sizeQ;
  logic        unsignedQ;
  logic [1:0]  offsetQ;    // Byte offset within the word
  logic [15:0] halfSel;
  logic [7:0]  byteSel;

  // Same alignment rule the formatter flags
  assign rdErr = isMisaligned(memReq.loadType.sign == LoadWord,
                              memReq.loadType.sign == LoadHalf, memReq.addr[1:0]);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pendingQ <= 1'b0;
    end else begin
      pendingQ <= memReq.loadType.ReadMem && !rdErr;
    end
  end

  // Load attributes travel alongside the RAM read
  always_ff @(posedge clk) begin
    sizeQ     <= memReq.loadType.sign;
    unsignedQ <= memReq.loadType.isUnsigned;
    offsetQ   <= memReq.addr[1:0];
  end

  assign halfSel = offsetQ[1] ? rdata[31:16] : rdata[15:0];
  assign byteSel = rdata[{offsetQ, 3'b000} +: 8];

  // Extract and extend
  always_comb begin
    case (sizeQ)
      LoadHalf: loadData = {{16{!unsignedQ && halfSel[15]}}, halfSel};
      LoadByte: loadData = {{24{!unsignedQ && byteSel[7]}}, byteSel};
      default:  loadData = rdata;  // Word
    endcase
  end

  assign loadDone = pendingQ;

  // Nothing can be in flight out of reset
  assert property (@(posedge clk) $rose(rstN) |-> !loadDone)
    else $error("LoadAligner: loadDone high right after reset release");

endmodule

//--- src/DataRam.sv
`timescale 1ns/1ps

module DataRam (
  input  logic                                clk,
  input  MemStagePkg::RamWriteType            ramWrite,
  input  logic [MemStagePkg::RamAddrBits-1:0] rdAddr,
  output logic [31:0]                         rdata
);

  import MemStagePkg::*;

  logic [31:0] mem [2**RamAddrBits];
  logic [31:0] readWord;  // Stored word with same-edge write merged in

  // Byte-lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (ramWrite.wen[i]) mem[ramWrite.wordAddr][8*i +: 8] <= ramWrite.wdata[8*i +: 8];
    end
  end

  // Write before read on a shared edge
  always_comb begin
    readWord = mem[rdAddr];
    if (ramWrite.wordAddr == rdAddr) begin
      for (int i = 0; i < 4; i++) begin
        if (ramWrite.wen[i]) readWord[8*i +: 8] = ramWrite.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    rdata <= readWord;  // One cycle read latency
  end

  // Only byte, aligned half, full word or idle
  assert property (@(posedge clk)
    ramWrite.wen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                         4'b0011, 4'b1100, 4'b1111})
    else $error("DataRam: illegal byte-enable pattern %b", ramWrite.wen);

endmodule

//--- src/StoreFormatter.sv
`timescale 1ns/1ps

module StoreFormatter (
  input  MemStagePkg::MemReqType       memReq,
  output MemStagePkg::RamWriteType     ramWrite,
  output MemStagePkg::ExceptinPipeType exceptOut
);

  import MemStagePkg::*;

  logic [31:0] laneData;  // Operand placed in its byte lanes
  logic [3:0]  laneWen;   // Enables before error suppression
  logic [1:0]  offset;
  logic        wrErr;
  logic        rdErr;

  assign offset = memReq.addr[1:0];

  // Lane placement by store kind
  always_comb begin
    laneData = '0;
    laneWen  = 4'b0000;
    if (memReq.storeType.DMWr) begin
      case (memReq.storeType.sign)
        StoreSw: begin
          laneData = memReq.storeData;
          laneWen  = 4'b1111;
        end
        StoreSh: begin
          if (offset[1]) begin
            laneData = {memReq.storeData[15:0], 16'b0};
            laneWen  = 4'b1100;
          end else begin
            laneData = {16'b0, memReq.storeData[15:0]};
            laneWen  = 4'b0011;
          end
        end
        StoreSb: begin
          laneData = {24'b0, memReq.storeData[7:0]} << {offset, 3'b000};
          laneWen  = 4'b0001 << offset;
        end
        default: begin
          laneData = '0;  // Unknown kind writes nothing
          laneWen  = 4'b0000;
        end
      endcase
    end
  end

  // Address errors for both directions
  assign wrErr = memReq.storeType.DMWr &&
                 isMisaligned(memReq.storeType.sign == StoreSw,
                              memReq.storeType.sign == StoreSh, offset);
  assign rdErr = memReq.loadType.ReadMem &&
                 isMisaligned(memReq.loadType.sign == LoadWord,
                              memReq.loadType.sign == LoadHalf, offset);

  // Upstream flags pass through, MEM flags come from here
  always_comb begin
    exceptOut                     = memReq.exceptIn;
    exceptOut.WrWrongAddressinMEM = wrErr;
    exceptOut.RdWrongAddressinMEM = rdErr;
  end

  assign ramWrite.wordAddr = memReq.addr[RamAddrBits+1:2];
  assign ramWrite.wen      = wrErr ? 4'b0000 : laneWen;  // Bad store never reaches RAM
  assign ramWrite.wdata    = laneData;

  // Enabled lanes only for aligned words, even halves or bytes
  always_comb begin
    assert final ((ramWrite.wen == 4'b0000) ||
                  (memReq.storeType.sign == StoreSw && offset == 2'b00) ||
                  (memReq.storeType.sign == StoreSh && !offset[0]) ||
                  (memReq.storeType.sign == StoreSb))
      else $error("StoreFormatter: write enabled on misaligned store");
  end

endmodule

//--- src/MemStagePkg.sv
package MemStagePkg;

  localparam int RamAddrBits = 10;  // Data RAM depth, log2 of words

  // Store kind codes, carried in StoreType.sign
  localparam logic [1:0] StoreSw = 2'b00;
  localparam logic [1:0] StoreSh = 2'b01;
  localparam logic [1:0] StoreSb = 2'b10;

  // Load size codes, carried in LoadType.sign
  localparam logic [1:0] LoadWord = 2'b00;
  localparam logic [1:0] LoadHalf = 2'b01;
  localparam logic [1:0] LoadByte = 2'b10;

  typedef struct packed {
    logic       DMWr;        // Write strobe, one cycle per store
    logic [1:0] sign;        // Store kind
  } StoreType;

  typedef struct packed {
    logic       ReadMem;     // Read strobe, one cycle per load
    logic [1:0] sign;        // Load size
    logic       isUnsigned;  // Zero extend instead of sign extend
  } LoadType;

  typedef struct packed {
    logic Interrupt;
    logic WrongAddressinIF;
    logic ReservedInstruction;
    logic Syscall;
    logic Break;
    logic Eret;
    logic WrWrongAddressinMEM;  // Raised in this stage
    logic RdWrongAddressinMEM;  // Raised in this stage
    logic Overflow;
  } ExceptinPipeType;

  // Request as it leaves the EX/MEM register
  typedef struct packed {
    logic [31:0]     addr;
    logic [31:0]     storeData;
    StoreType        storeType;
    LoadType         loadType;
    ExceptinPipeType exceptIn;
  } MemReqType;

  typedef struct packed {
    logic [RamAddrBits-1:0] wordAddr;
    logic [3:0]             wen;    // One bit per byte lane
    logic [31:0]            wdata;  // Already shifted into lanes
  } RamWriteType;

  // Alignment rule shared by loads and stores
  function automatic logic isMisaligned(logic isWord, logic isHalf, logic [1:0] offset);
    return (isWord && (offset != 2'b00)) || (isHalf && offset[0]);
  endfunction

endpackage
